// ==== verification/wb_ctrl_vectors.txt ====
# in: en wb(vld ill ebk ecl bus mpu wfi fnc mrt drq) pipe(ex id) dec(xfer mret_id jr) ex(br dreq done) irq id wu
# exp: busy/req/pcset pcmux excmux ack id save(if id ex wb) cause savecause/restore halt(if id ex wb) kill(if id ex wb) wake
# Reset and boot
0 0000000000 00 0000 000 0 00 0  100 0 1 0 00 0000 00 00 0000 0000 0
0 0000000000 00 0000 000 0 00 0  100 0 1 0 00 0000 00 00 0000 0000 0
1 0000000000 00 0000 000 0 00 0  100 0 1 0 00 0000 00 00 0000 0000 0
1 0000000000 00 0000 000 0 00 0  111 0 1 0 00 0000 00 00 0000 1000 0
1 0000000000 00 0000 000 0 00 0  110 0 1 0 00 0000 00 00 0000 0000 0
# Exception causes and priority
1 1100000000 00 0000 000 0 00 0  111 4 0 0 00 0001 02 10 0000 1110 0
1 1010000000 00 0000 000 0 00 0  111 4 0 0 00 0001 03 10 0000 1110 0
1 1001000000 00 0000 000 0 00 0  111 4 0 0 00 0001 0b 10 0000 1110 0
1 1000100000 00 0000 000 0 00 0  111 4 0 0 00 0001 18 10 0000 1110 0
1 1000010000 00 0000 000 0 00 0  111 4 0 0 00 0001 01 10 0000 1110 0
1 1101010000 00 0000 000 0 00 0  111 4 0 0 00 0001 01 10 0000 1110 0
1 1100100000 00 0000 000 0 00 0  111 4 0 0 00 0001 18 10 0000 1110 0
1 1111000000 00 0000 000 0 00 0  111 4 0 0 00 0001 02 10 0000 1110 0
1 1011000000 00 0000 000 0 00 0  111 4 0 0 00 0001 0b 10 0000 1110 0
1 0100000000 00 0000 000 0 00 0  110 0 1 0 00 0000 00 00 0000 0000 0
1 1100001100 00 0000 100 0 00 0  111 4 0 0 00 0001 02 10 0000 1110 0
# Interrupt gating
1 1000000001 00 0000 010 1 0b 0  110 0 1 0 00 0000 00 00 0100 0000 0
1 0000000000 00 0000 000 1 0b 0  110 0 1 0 00 0000 00 00 0100 0000 0
1 0000000000 00 0000 001 1 0b 0  110 0 1 0 00 0000 00 00 0100 0000 0
1 0000000000 11 0000 000 1 0b 0  111 4 1 1 0b 0010 2b 10 0000 1111 0
1 0000000000 01 0000 000 1 1f 0  111 4 1 1 1f 0100 3f 10 0000 1111 0
1 0000000000 00 0000 000 1 03 0  111 4 1 1 03 1000 23 10 0000 1111 0
1 1100000001 11 0000 010 1 07 0  111 4 1 1 07 0001 27 10 0000 1111 0
1 1100000000 00 0000 000 1 07 0  111 4 1 1 07 0001 27 10 0000 1111 0
1 0000000000 00 0000 001 0 00 0  110 0 1 0 00 0000 00 00 0000 0000 0
1 0000000000 00 0000 000 1 05 0  111 4 1 1 05 1000 25 10 0000 1111 0
# WFI and sleep
1 1000001000 00 0000 000 0 00 0  100 0 1 0 00 0000 00 00 1100 0000 0
1 0000000000 00 0000 000 0 00 0  000 0 1 0 00 0000 00 00 1111 0000 0
1 0000000000 00 0000 000 0 00 0  000 0 1 0 00 0000 00 00 1111 0000 0
1 0000000000 00 0000 000 0 00 1  100 0 1 0 00 0000 00 00 1111 0000 1
1 0000000000 00 0000 000 0 00 0  110 0 1 0 00 0000 00 00 0000 0000 0
# FENCE.I, MRET in WB, branch and jumps
1 1000000100 00 0000 000 0 00 0  111 1 1 0 00 0000 00 00 0000 1110 0
1 1000000010 00 0000 000 0 00 0  110 0 1 0 00 0000 00 01 0000 0000 0
1 0000000000 00 0000 100 0 00 0  111 3 1 0 00 0000 00 00 0000 1100 0
1 0000000000 01 0100 000 0 00 0  111 2 1 0 00 0000 00 00 0000 1000 0
1 0000000000 01 1001 000 0 00 0  110 2 1 0 00 0000 00 00 0000 1000 0
1 0000000000 01 1000 000 0 00 0  111 2 1 0 00 0000 00 00 0000 1000 0
1 0000000000 01 0010 000 0 00 0  111 5 1 0 00 0000 00 00 0000 1000 0
1 0000000000 00 0100 000 0 00 0  110 0 1 0 00 0000 00 00 0000 0000 0
1 0000000000 01 1100 000 0 00 0  110 0 1 0 00 0000 00 00 0000 0000 0
1 0000000000 00 0000 000 0 00 1  110 0 1 0 00 0000 00 00 0000 0000 1
1 0000000000 00 0000 000 0 00 0  110 0 1 0 00 0000 00 00 0000 0000 0

// ==== wb_ctrl.f ====
+incdir+include
design/wb_ctrl_pkg.sv
design/wb_event_decode.sv
design/irq_gate.sv
design/ctrl_fsm.sv
design/wb_ctrl_top.sv
verification/wb_ctrl_chk.sv
verification/wb_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the write-back controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f wb_ctrl.f --top-module wb_ctrl_tb -o wb_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/wb_ctrl_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

// ==== verification/wb_ctrl_tb.sv ====
// Write-back controller testbench

`include "wb_ctrl_config.svh"

module wb_ctrl_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import wb_ctrl_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int IN_W         = 27;   // Input bits per vector
  localparam int EXP_W        = 39;   // Expected bits with the irq id twice
  localparam int NUM_FIELDS   = 19;   // Columns per vector line
  localparam int NUM_CHECKS   = 15;

  // Position and width of each output field in the expected vector
  localparam int FIELD_LSB [NUM_CHECKS] = '{38, 37, 36, 33, 32, 31, 26, 22, 16, 15, 14,
                                            10, 6, 5, 0};
  localparam int FIELD_W [NUM_CHECKS]   = '{1, 1, 1, 3, 1, 1, 5, 4, 6, 1, 1, 4, 4, 1, 5};

  string field_name [NUM_CHECKS] = '{"ctrl_busy_o", "instr_req_o", "pc_set_o", "pc_mux_o",
                                     "exc_pc_mux_o", "irq_ack_o", "irq_id_o",
                                     "csr_save_{if,id,ex,wb}_o", "csr_cause_o",
                                     "csr_save_cause_o", "csr_restore_mret_o",
                                     "halt_{if,id,ex,wb}_o", "kill_{if,id,ex,wb}_o",
                                     "wake_o", "exc_cause_o"};

  logic clk;
  logic rst_n;

  // DUT inputs named as the ports
  logic        fetch_enable_i;
  logic        wb_valid_i, wb_illegal_i, wb_ebrk_i, wb_ecall_i, wb_bus_err_i;
  logic        wb_mpu_err_i, wb_wfi_i, wb_fencei_i, wb_mret_i, wb_data_req_i;
  logic        ex_instr_valid_i, id_instr_valid_i;
  logic [1:0]  xfer_bits;              // Raw ctrl_xfer_i bits cast at the port
  logic        mret_id_i, jr_stall_i;
  logic        branch_taken_ex_i, data_req_i, ex_done_i;
  logic        irq_req_i;
  irq_id_t     irq_id_i;
  logic        irq_wu_i;

  // DUT outputs
  logic        ctrl_busy_o, instr_req_o, pc_set_o;
  pc_mux_e     pc_mux_o;
  exc_pc_mux_e exc_pc_mux_o;
  irq_id_t     exc_cause_o, irq_id_o;
  logic        irq_ack_o;
  logic        csr_save_if_o, csr_save_id_o, csr_save_ex_o, csr_save_wb_o;
  cause_t      csr_cause_o;
  logic        csr_save_cause_o, csr_restore_mret_o;
  logic        halt_if_o, halt_id_o, halt_ex_o, halt_wb_o;
  logic        kill_if_o, kill_id_o, kill_ex_o, kill_wb_o;
  logic        wake_o;

  logic [IN_W-1:0]  in_q [$];          // One entry per cycle
  logic [EXP_W-1:0] exp_q [$];
  int value_errors = 0;
  int other_errors = 0;
  int cycle_cnt    = 0;
  int cycle_limit  = 1000;             // Replaced once the vectors are known

  wb_ctrl_top UUT (
    .*,
    .ctrl_xfer_i (xfer_e'(xfer_bits))
  );

  //////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;             // 8 ns period
  end

  initial begin
    @(posedge clk);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Vector file
  //////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int                          fd;
    int                          n;
    string                       line;
    logic                        en, irq, wu, excmux, ack, wake;
    logic [9:0]                  wb;
    logic [1:0]                  pipe, csr;
    logic [3:0]                  dec, save, halt, kill;
    logic [2:0]                  ex, ctl, pcmux;
    logic [`WB_CTRL_IRQ_ID_W-1:0] id, ack_id;
    logic [`WB_CTRL_CAUSE_W-1:0]  cause;
    fd = $fopen("verification/wb_ctrl_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      other_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
      n = $sscanf(line, "%b %b %b %b %b %b %h %b %b %h %b %b %h %b %h %b %b %b %b",
                  en, wb, pipe, dec, ex, irq, id, wu,
                  ctl, pcmux, excmux, ack, ack_id, save, cause, csr, halt, kill, wake);
      if (n != NUM_FIELDS) begin
        $display("Malformed vector line: %s", line);
        other_errors++;
      end else begin
        in_q.push_back({en, wb, pipe, dec, ex, irq, id, wu});
        exp_q.push_back({ctl, pcmux, excmux, ack, ack_id, save, cause, csr,
                         halt, kill, wake, ack_id});
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output check
  //////////////////////////////////////////////////////////////////////

  task automatic check_outputs(input logic [EXP_W-1:0] expected);
    logic [EXP_W-1:0] actual;
    logic [EXP_W-1:0] mask;
    logic [EXP_W-1:0] exp_f;
    logic [EXP_W-1:0] act_f;
    int               k;
    actual = {ctrl_busy_o, instr_req_o, pc_set_o, pc_mux_o, exc_pc_mux_o, irq_ack_o,
              irq_id_o, csr_save_if_o, csr_save_id_o, csr_save_ex_o, csr_save_wb_o,
              csr_cause_o, csr_save_cause_o, csr_restore_mret_o,
              halt_if_o, halt_id_o, halt_ex_o, halt_wb_o,
              kill_if_o, kill_id_o, kill_ex_o, kill_wb_o, wake_o, exc_cause_o};
    for (k = 0; k < NUM_CHECKS; k++) begin
      mask  = (EXP_W'(1) << FIELD_W[k]) - EXP_W'(1);
      exp_f = (expected >> FIELD_LSB[k]) & mask;
      act_f = (actual >> FIELD_LSB[k]) & mask;
      assert (act_f == exp_f) else begin
        value_errors++;
        $display("Fail at %0d ns: %s expected %0h, got %0h",
                 $time, field_name[k], exp_f, act_f);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    {fetch_enable_i, wb_valid_i, wb_illegal_i, wb_ebrk_i, wb_ecall_i, wb_bus_err_i,
     wb_mpu_err_i, wb_wfi_i, wb_fencei_i, wb_mret_i, wb_data_req_i,
     ex_instr_valid_i, id_instr_valid_i, xfer_bits, mret_id_i, jr_stall_i,
     branch_taken_ex_i, data_req_i, ex_done_i, irq_req_i, irq_id_i, irq_wu_i} = '0;
    load_vectors();
    if (in_q.size() == 0) begin
      $display("No vectors were loaded");
      other_errors++;
    end
    cycle_limit = in_q.size() + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    foreach (in_q[i]) begin
      @(posedge clk);
      {fetch_enable_i, wb_valid_i, wb_illegal_i, wb_ebrk_i, wb_ecall_i, wb_bus_err_i,
       wb_mpu_err_i, wb_wfi_i, wb_fencei_i, wb_mret_i, wb_data_req_i,
       ex_instr_valid_i, id_instr_valid_i, xfer_bits, mret_id_i, jr_stall_i,
       branch_taken_ex_i, data_req_i, ex_done_i, irq_req_i, irq_id_i, irq_wu_i} <= in_q[i];
      @(negedge clk);                  // Outputs settled mid cycle
      check_outputs(exp_q[i]);
    end
    @(posedge clk);
    $display("Summary: %0d vectors, %0d value errors, %0d other errors",
             in_q.size(), value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/wb_ctrl_chk.sv ====
// Controller output assertions

module wb_ctrl_chk (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     csr_save_if_i,
  input logic                     csr_save_id_i,
  input logic                     csr_save_ex_i,
  input logic                     csr_save_wb_i,
  input logic                     irq_ack_i,
  input logic                     pc_set_i,
  input wb_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input logic                     halt_wb_i,
  input logic                     instr_req_i,
  input logic                     kill_wb_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import wb_ctrl_pkg::*;

  // Only one stage PC goes to mepc
  a_save_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({csr_save_if_i, csr_save_id_i, csr_save_ex_i, csr_save_wb_i}))
    else $error("More than one csr_save output is high");

  a_ack_vector: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_i |-> (pc_set_i && exc_pc_mux_i == EXC_PC_IRQ))   // Ack jumps to irq vector
    else $error("irq_ack_o without pc_set_o to the interrupt vector");

  // Sleeping core must not fetch
  a_halt_no_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    halt_wb_i |-> !instr_req_i)
    else $error("Fetch request while write-back is halted");

  a_kill_wb_irq: assert property (@(posedge clk) disable iff (!rst_n)
    kill_wb_i |-> irq_ack_i)     // Only interrupts flush WB
    else $error("kill_wb_o without an interrupt acknowledge");

endmodule

bind wb_ctrl_top wb_ctrl_chk u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .csr_save_if_i (csr_save_if_o),
  .csr_save_id_i (csr_save_id_o),
  .csr_save_ex_i (csr_save_ex_o),
  .csr_save_wb_i (csr_save_wb_o),
  .irq_ack_i     (irq_ack_o),
  .pc_set_i      (pc_set_o),
  .exc_pc_mux_i  (exc_pc_mux_o),
  .halt_wb_i     (halt_wb_o),
  .instr_req_i   (instr_req_o),
  .kill_wb_i     (kill_wb_o)
);

// ==== design/wb_ctrl_top.sv ====
// Write-back stage controller

module wb_ctrl_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_enable_i,

  // Write-back instruction
  input  logic                     wb_valid_i,
  input  logic                     wb_illegal_i,
  input  logic                     wb_ebrk_i,
  input  logic                     wb_ecall_i,
  input  logic                     wb_bus_err_i,
  input  logic                     wb_mpu_err_i,
  input  logic                     wb_wfi_i,
  input  logic                     wb_fencei_i,
  input  logic                     wb_mret_i,
  input  logic                     wb_data_req_i,

  input  logic                     ex_instr_valid_i,
  input  logic                     id_instr_valid_i,

  // Decode
  input  wb_ctrl_pkg::xfer_e       ctrl_xfer_i,
  input  logic                     mret_id_i,
  input  logic                     jr_stall_i,

  // Execute
  input  logic                     branch_taken_ex_i,
  input  logic                     data_req_i,
  input  logic                     ex_done_i,

  // Interrupt controller
  input  logic                     irq_req_i,
  input  wb_ctrl_pkg::irq_id_t     irq_id_i,
  input  logic                     irq_wu_i,

  output logic                     ctrl_busy_o,
  output logic                     instr_req_o,
  output logic                     pc_set_o,
  output wb_ctrl_pkg::pc_mux_e     pc_mux_o,
  output wb_ctrl_pkg::exc_pc_mux_e exc_pc_mux_o,
  output wb_ctrl_pkg::irq_id_t     exc_cause_o,
  output logic                     irq_ack_o,
  output wb_ctrl_pkg::irq_id_t     irq_id_o,
  output logic                     csr_save_if_o,
  output logic                     csr_save_id_o,
  output logic                     csr_save_ex_o,
  output logic                     csr_save_wb_o,
  output wb_ctrl_pkg::cause_t      csr_cause_o,
  output logic                     csr_save_cause_o,
  output logic                     csr_restore_mret_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,
  output logic                     halt_ex_o,
  output logic                     halt_wb_o,
  output logic                     kill_if_o,
  output logic                     kill_id_o,
  output logic                     kill_ex_o,
  output logic                     kill_wb_o,
  output logic                     wake_o
);

  import wb_ctrl_pkg::*;

  logic        exc_event;     // Decoder results
  cause_t      exc_code;
  logic        wfi_event;
  logic        fencei_event;
  logic        mret_event;
  logic        irq_allowed;   // Gate results
  save_stage_e save_stage;

  wb_event_decode u_decode (
    .*,
    .exc_event_o    (exc_event),
    .exc_code_o     (exc_code),
    .wfi_event_o    (wfi_event),
    .fencei_event_o (fencei_event),
    .mret_event_o   (mret_event)
  );

  irq_gate u_irq_gate (
    .*,
    .exc_event_i   (exc_event),
    .irq_allowed_o (irq_allowed),
    .save_stage_o  (save_stage)
  );

  ctrl_fsm u_fsm (
    .*,
    .exc_event_i    (exc_event),
    .wfi_event_i    (wfi_event),
    .fencei_event_i (fencei_event),
    .mret_event_i   (mret_event),
    .exc_code_i     (exc_code),
    .irq_allowed_i  (irq_allowed),
    .save_stage_i   (save_stage)
  );

endmodule

// ==== design/ctrl_fsm.sv ====
// Write-back controller FSM

`include "wb_ctrl_config.svh"

module ctrl_fsm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_enable_i,     // Leave reset, start booting

  // Events from WB
  input  logic                     exc_event_i,
  input  logic                     wfi_event_i,
  input  logic                     fencei_event_i,
  input  logic                     mret_event_i,
  input  wb_ctrl_pkg::cause_t      exc_code_i,

  // Interrupt gating
  input  logic                     irq_allowed_i,
  input  wb_ctrl_pkg::save_stage_e save_stage_i,
  input  logic                     irq_req_i,
  input  wb_ctrl_pkg::irq_id_t     irq_id_i,
  input  logic                     irq_wu_i,           // Wake-up request

  // EX and ID
  input  logic                     branch_taken_ex_i,
  input  wb_ctrl_pkg::xfer_e       ctrl_xfer_i,
  input  logic                     mret_id_i,
  input  logic                     id_instr_valid_i,
  input  logic                     jr_stall_i,         // JALR operand not ready

  output logic                     ctrl_busy_o,
  output logic                     instr_req_o,
  output logic                     pc_set_o,
  output wb_ctrl_pkg::pc_mux_e     pc_mux_o,
  output wb_ctrl_pkg::exc_pc_mux_e exc_pc_mux_o,
  output wb_ctrl_pkg::irq_id_t     exc_cause_o,        // Vector offset for IF
  output logic                     irq_ack_o,
  output wb_ctrl_pkg::irq_id_t     irq_id_o,
  output logic                     csr_save_if_o,
  output logic                     csr_save_id_o,
  output logic                     csr_save_ex_o,
  output logic                     csr_save_wb_o,
  output wb_ctrl_pkg::cause_t      csr_cause_o,
  output logic                     csr_save_cause_o,
  output logic                     csr_restore_mret_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,
  output logic                     halt_ex_o,
  output logic                     halt_wb_o,
  output logic                     kill_if_o,
  output logic                     kill_id_o,
  output logic                     kill_ex_o,
  output logic                     kill_wb_o,
  output logic                     wake_o
);

  import wb_ctrl_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        jump_in_id;  // JAL, JALR or mret decoded in ID

  assign jump_in_id = ((ctrl_xfer_i == XFER_JAL) ||
                       (ctrl_xfer_i == XFER_JALR) ||
                       mret_id_i) && id_instr_valid_i;

  assign wake_o = irq_wu_i;

  //////////////////////////////////////////////////////////////////////
  // Next state and controls
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    ctrl_busy_o        = 1'b1;
    instr_req_o        = 1'b1;       // Fetch unless told otherwise
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    exc_cause_o        = '0;
    irq_ack_o          = 1'b0;
    irq_id_o           = '0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_ex_o      = 1'b0;
    csr_save_wb_o      = 1'b0;
    csr_cause_o        = '0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    halt_if_o          = 1'b0;
    halt_id_o          = 1'b0;
    halt_ex_o          = 1'b0;
    halt_wb_o          = 1'b0;
    kill_if_o          = 1'b0;
    kill_id_o          = 1'b0;
    kill_ex_o          = 1'b0;
    kill_wb_o          = 1'b0;

    unique case (state_q)
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) state_d = BOOT_SET;
      end
      BOOT_SET: begin                // Single cycle, load the boot address
        pc_set_o  = 1'b1;
        pc_mux_o  = PC_BOOT;
        kill_if_o = 1'b1;
        state_d   = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (irq_req_i) begin
          if (irq_allowed_i) begin
            kill_if_o        = 1'b1;   // Flush everything
            kill_id_o        = 1'b1;
            kill_ex_o        = 1'b1;
            kill_wb_o        = 1'b1;
            pc_set_o         = 1'b1;
            pc_mux_o         = PC_EXCEPTION;
            exc_pc_mux_o     = EXC_PC_IRQ;
            exc_cause_o      = irq_id_i;
            irq_ack_o        = 1'b1;
            irq_id_o         = irq_id_i;
            csr_save_cause_o = 1'b1;
            csr_cause_o      = {1'b1, irq_id_i};  // Interrupt flag set
            unique case (save_stage_i)
              SAVE_WB: csr_save_wb_o = 1'b1;
              SAVE_EX: csr_save_ex_o = 1'b1;
              SAVE_ID: csr_save_id_o = 1'b1;
              default: csr_save_if_o = 1'b1;
            endcase
          end else begin
            halt_id_o = 1'b1;          // Hold decode until the bus access ends
          end
        end else if (exc_event_i) begin
          kill_if_o        = 1'b1;     // WB instruction itself retires as trap
          kill_id_o        = 1'b1;
          kill_ex_o        = 1'b1;
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_EXCEPTION;
          csr_save_wb_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          csr_cause_o      = {1'b0, exc_code_i[`WB_CTRL_IRQ_ID_W-1:0]};
        end else if (wfi_event_i) begin
          // EX and WB keep going so the bubble behind WFI drains
          halt_if_o   = 1'b1;
          halt_id_o   = 1'b1;
          instr_req_o = 1'b0;
          state_d     = SLEEP;
        end else if (fencei_event_i) begin
          kill_if_o = 1'b1;            // Refetch from WB pc + 4
          kill_id_o = 1'b1;
          kill_ex_o = 1'b1;
          pc_set_o  = 1'b1;
          pc_mux_o  = PC_FENCEI;
        end else if (mret_event_i) begin
          csr_restore_mret_o = 1'b1;   // Jump already taken from ID
        end else if (branch_taken_ex_i) begin
          kill_if_o = 1'b1;
          kill_id_o = 1'b1;
          pc_set_o  = 1'b1;
          pc_mux_o  = PC_BRANCH;
        end else if (jump_in_id) begin
          kill_if_o = 1'b1;
          if (mret_id_i) begin
            pc_set_o = 1'b1;
            pc_mux_o = PC_MRET;
          end else begin
            pc_mux_o = PC_JUMP;
            pc_set_o = !jr_stall_i;    // Wait for the JALR base register
          end
        end
      end
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        halt_ex_o   = 1'b1;
        halt_wb_o   = 1'b1;
        if (wake_o) begin
          ctrl_busy_o = 1'b1;          // Clock gate opens in this cycle
          state_d     = FUNCTIONAL;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== design/irq_gate.sv ====
// Interrupt gate

module irq_gate (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     wb_valid_i,        // WB holds a valid instruction
  input  logic                     wb_data_req_i,     // WB instruction is a load/store
  input  logic                     ex_instr_valid_i,
  input  logic                     id_instr_valid_i,
  input  logic                     data_req_i,        // LSU request leaving EX
  input  logic                     ex_done_i,         // EX stage finished its instruction
  input  logic                     exc_event_i,       // Exception in WB overrides gating

  output logic                     irq_allowed_o,
  output wb_ctrl_pkg::save_stage_e save_stage_o
);

  import wb_ctrl_pkg::*;

  logic data_req_q;      // A request left EX and the instruction is still there
  logic wb_lsu_active;   // Valid load/store sitting in WB

  //////////////////////////////////////////////////////////////////////
  // Outstanding data request
  //////////////////////////////////////////////////////////////////////

  // Set while the LSU instruction waits in EX after issuing its request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_req_q <= 1'b0;
    end else begin
      if (data_req_i && !ex_done_i) begin
        data_req_q <= 1'b1;
      end else if (ex_done_i) begin
        data_req_q <= 1'b0;  // Instruction moved on to WB
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Interrupt permission
  //////////////////////////////////////////////////////////////////////

  assign wb_lsu_active = wb_valid_i && wb_data_req_i;

  // A bus access already on its way must complete.
  // A faulting instruction never reached the bus, so it is interruptible.
  assign irq_allowed_o = (!wb_lsu_active && !data_req_q) || exc_event_i;

  //////////////////////////////////////////////////////////////////////
  // Saved PC stage
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (wb_valid_i) begin
      save_stage_o = SAVE_WB;       // Oldest first
    end else if (ex_instr_valid_i) begin
      save_stage_o = SAVE_EX;
    end else if (id_instr_valid_i) begin
      save_stage_o = SAVE_ID;
    end else begin
      save_stage_o = SAVE_IF;       // Pipe empty, IF pc is next to run
    end
  end

endmodule

// ==== design/wb_event_decode.sv ====
// Write-back event decoder

`include "wb_ctrl_config.svh"

module wb_event_decode (
  input  logic                wb_valid_i,      // WB holds a valid instruction
  input  logic                wb_illegal_i,    // Illegal instruction
  input  logic                wb_ebrk_i,       // ebreak
  input  logic                wb_ecall_i,      // ecall
  input  logic                wb_bus_err_i,    // Instruction fetch bus error
  input  logic                wb_mpu_err_i,    // MPU blocked the fetch
  input  logic                wb_wfi_i,
  input  logic                wb_fencei_i,
  input  logic                wb_mret_i,

  output logic                exc_event_o,     // Synchronous exception in WB
  output wb_ctrl_pkg::cause_t exc_code_o,      // Cause of that exception
  output logic                wfi_event_o,
  output logic                fencei_event_o,
  output logic                mret_event_o
);

  logic any_fault;  // Unqualified OR of all fault flags

  //////////////////////////////////////////////////////////////////////
  // Exception detection
  //////////////////////////////////////////////////////////////////////

  assign any_fault = wb_illegal_i ||
                     wb_ebrk_i    ||
                     wb_ecall_i   ||
                     wb_bus_err_i ||
                     wb_mpu_err_i;

  assign exc_event_o = any_fault && wb_valid_i;  // Bubbles never trap

  // Fixed priority, fetch faults first since the opcode is junk then
  always_comb begin
    if (wb_mpu_err_i) begin
      exc_code_o = `WB_CTRL_EXC_INSTR_FAULT;
    end else if (wb_bus_err_i) begin
      exc_code_o = `WB_CTRL_EXC_INSTR_BUS_FAULT;
    end else if (wb_illegal_i) begin
      exc_code_o = `WB_CTRL_EXC_ILLEGAL;
    end else if (wb_ecall_i) begin
      exc_code_o = `WB_CTRL_EXC_ECALL_M;
    end else begin
      exc_code_o = `WB_CTRL_EXC_BREAKPOINT;  // Only ebreak left
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Special instructions
  //////////////////////////////////////////////////////////////////////

  assign wfi_event_o    = wb_wfi_i    && wb_valid_i;
  assign fencei_event_o = wb_fencei_i && wb_valid_i;
  assign mret_event_o   = wb_mret_i   && wb_valid_i;  // CSR restore only

endmodule

// ==== design/wb_ctrl_pkg.sv ====
// Write-back controller types

`include "wb_ctrl_config.svh"

package wb_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vectors
  //////////////////////////////////////////////////////////////////////

  typedef logic [`WB_CTRL_IRQ_ID_W-1:0] irq_id_t;  // Interrupt id
  typedef logic [`WB_CTRL_CAUSE_W-1:0]  cause_t;   // mcause, flag in MSB

  //////////////////////////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////////////////////////

  // Control transfer kind reported by the decoder
  typedef enum logic [1:0] {
    XFER_NONE   = 2'b00,
    XFER_JAL    = 2'b01,
    XFER_JALR   = 2'b10,
    XFER_BRANCH = 2'b11   // Conditional branch, resolved in EX
  } xfer_e;

  // Fetch PC source
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,  // WB pc + 4
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,  // Trap vector, see exc_pc_mux
    PC_MRET      = 3'b101   // mepc
  } pc_mux_e;

  // Trap vector target
  typedef enum logic {
    EXC_PC_EXCEPTION = 1'b0,
    EXC_PC_IRQ       = 1'b1
  } exc_pc_mux_e;

  // Stage whose PC goes to mepc on an interrupt
  typedef enum logic [1:0] {
    SAVE_IF = 2'b00,
    SAVE_ID = 2'b01,
    SAVE_EX = 2'b10,
    SAVE_WB = 2'b11
  } save_stage_e;

  // Controller FSM
  typedef enum logic [1:0] {
    RESET,
    BOOT_SET,
    FUNCTIONAL,
    SLEEP
  } ctrl_state_e;

endpackage

// ==== include/wb_ctrl_config.svh ====
// Write-back controller configuration

`ifndef WB_CTRL_CONFIG_SVH
`define WB_CTRL_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

// Interrupt id, as delivered by the interrupt controller
`define WB_CTRL_IRQ_ID_W 5

// mcause value, interrupt flag sits on top of the id
`define WB_CTRL_CAUSE_W 6

//////////////////////////////////////////////////////////////////////
// Synchronous exception cause codes (mcause, flag clear)
//////////////////////////////////////////////////////////////////////

// Instruction access fault, raised by the MPU
`define WB_CTRL_EXC_INSTR_FAULT 6'd1

// Instruction bus error, custom code
`define WB_CTRL_EXC_INSTR_BUS_FAULT 6'd24

`define WB_CTRL_EXC_ILLEGAL 6'd2      // Illegal instruction

`define WB_CTRL_EXC_ECALL_M 6'd11     // Environment call from M-mode

`define WB_CTRL_EXC_BREAKPOINT 6'd3   // ebreak

`endif
